// ==== apb_pkg.sv ====
package apb_pkg;

   // Bus side of the slave port

   // Address bus width
   // Covers a 4 KB peripheral window
   localparam int apb_addr_w = 12;

   // Data bus width
   localparam int apb_data_w = 32;

   // Lowest address bit that picks a register word
   // Bits below it hold the byte offset
   // Always zero on word access
   localparam int apb_word_lsb = 2;

   // Bytes per bus word
   localparam int apb_word_bytes = apb_data_w / 8;

endpackage

// ==== gpio_apb_regs.sv ====
`timescale 1ns/1ps

module gpio_apb_regs import apb_pkg::*, gpio_pkg::*; (
   input  logic                  clk_apb,
   input  logic                  rst_apb_n,
   // APB slave port
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [apb_addr_w-1:0] paddr,
   input  logic [apb_data_w-1:0] pwdata,
   output logic [apb_data_w-1:0] prdata,
   output logic                  pready,
   output logic                  pslverr,
   // Read back from the pad pipeline
   input  logic [gpio_n-1:0]     sync_in,
   input  logic [gpio_n-1:0]     status,
   // Configuration out
   output logic [gpio_n-1:0]     pad_out,
   output logic [gpio_n-1:0]     rise_en,
   output logic [gpio_n-1:0]     fall_en,
   // One-cycle clear pulses for the status bits
   output logic [gpio_n-1:0]     status_clr
);

   // Word index from the address
   logic [reg_idx_w-1:0]  word_idx;
   // Transfer phase decode
   logic                  rd_en;
   logic                  wr_en;
   // Configuration registers
   logic [gpio_n-1:0]     data_out_q;
   logic [gpio_n-1:0]     rise_en_q;
   logic [gpio_n-1:0]     fall_en_q;
   // Selected read word before gating
   logic [apb_data_w-1:0] rd_mux;

   assign word_idx = paddr[apb_word_lsb +: reg_idx_w];

   // Read is valid over both phases of the transfer
   assign rd_en = psel & ~pwrite;
   // Write lands in the setup phase only
   assign wr_en = psel & ~penable & pwrite;

   // Configuration write
   // Read-only and unmapped words fall through to default
   always_ff @(posedge clk_apb or negedge rst_apb_n) begin
      if (rst_apb_n == 1'b0) begin
         data_out_q <= data_out_rst;
         rise_en_q  <= rise_en_rst;
         fall_en_q  <= fall_en_rst;
      end else if (wr_en) begin
         case (word_idx)
            reg_data_out: begin
               data_out_q <= pwdata[gpio_n-1:0];
            end
            reg_rise_en: begin
               rise_en_q <= pwdata[gpio_n-1:0];
            end
            reg_fall_en: begin
               fall_en_q <= pwdata[gpio_n-1:0];
            end
            default: begin
            end
         endcase
      end
   end

   // Clear pulse for IRQ_STATUS
   // Only one setup cycle per write, so the vector is a single pulse
   always_comb begin
      status_clr = '0;
      if (wr_en && (word_idx == reg_irq_status)) begin
         status_clr = pwdata[gpio_n-1:0];
      end
   end

   // Read mux
   always_comb begin
      case (word_idx)
         reg_data_out: begin
            rd_mux = apb_data_w'(data_out_q);
         end
         reg_data_in: begin
            rd_mux = apb_data_w'(sync_in);
         end
         reg_rise_en: begin
            rd_mux = apb_data_w'(rise_en_q);
         end
         reg_fall_en: begin
            rd_mux = apb_data_w'(fall_en_q);
         end
         reg_irq_status: begin
            rd_mux = apb_data_w'(status);
         end
         // Holes read as zero
         default: begin
            rd_mux = '0;
         end
      endcase
   end

   // Bus is quiet outside a read
   assign prdata = rd_en ? rd_mux : '0;

   // No wait states, no error response
   assign pready  = 1'b1;
   assign pslverr = 1'b0;

   // Configuration to the pads and the irq stage
   assign pad_out = data_out_q;
   assign rise_en = rise_en_q;
   assign fall_en = fall_en_q;

endmodule

// ==== gpio_chk.sv ====
`timescale 1ns/1ps

module gpio_chk import apb_pkg::*, gpio_pkg::*; (
   input logic                  clk_apb,
   input logic                  rst_apb_n,
   // APB response side
   input logic                  psel,
   input logic                  pwrite,
   input logic [apb_data_w-1:0] prdata,
   input logic                  pready,
   input logic                  pslverr,
   // Irq stage nets inside the top level
   input logic [gpio_n-1:0]     rise_evt,
   input logic [gpio_n-1:0]     fall_evt,
   input logic [gpio_n-1:0]     status,
   input logic                  irq
);

   // No wait states ever
   a_pready: assert property (@(posedge clk_apb) disable iff (!rst_apb_n) pready == 1'b1)
      else $error("pready low");

   // No error response ever
   a_pslverr: assert property (@(posedge clk_apb) disable iff (!rst_apb_n) pslverr == 1'b0)
      else $error("pslverr high");

   // Quiet read bus outside a read
   a_prdata_idle: assert property (@(posedge clk_apb) disable iff (!rst_apb_n)
      (psel && !pwrite) || (prdata == '0))
      else $error("prdata not zero outside a read");

   // Interrupt line follows the status word
   a_irq_or: assert property (@(posedge clk_apb) disable iff (!rst_apb_n) irq == |status)
      else $error("irq differs from OR of status");

   // A status bit only rises after an edge on its pin
   a_status_set: assert property (@(posedge clk_apb) disable iff (!rst_apb_n)
      ((status & ~$past(status)) & ~$past(rise_evt | fall_evt)) == '0)
      else $error("status bit set without an edge event");

endmodule

// Bound into the top level where the irq stage nets live
bind gpio_top gpio_chk u_chk (
   .clk_apb   (clk_apb),
   .rst_apb_n (rst_apb_n),
   .psel      (psel),
   .pwrite    (pwrite),
   .prdata    (prdata),
   .pready    (pready),
   .pslverr   (pslverr),
   .rise_evt  (rise_evt),
   .fall_evt  (fall_evt),
   .status    (status),
   .irq       (irq)
);

// ==== gpio_in_capture.sv ====
`timescale 1ns/1ps

module gpio_in_capture import gpio_pkg::*; (
   input  logic              clk_apb,
   input  logic              rst_apb_n,
   // Raw asynchronous pad levels
   input  logic [gpio_n-1:0] pad_in,
   // Second synchronizer stage
   output logic [gpio_n-1:0] sync_in,
   // One-cycle edge pulses
   output logic [gpio_n-1:0] rise_evt,
   output logic [gpio_n-1:0] fall_evt
);

   // First stage may go metastable
   logic [gpio_n-1:0] meta_q;
   // Second stage is safe in the clock domain
   logic [gpio_n-1:0] sync_q;
   // Sync value one cycle back
   logic [gpio_n-1:0] prev_q;

   // Two-flop synchronizer
   // Each pin is sampled on its own
   // No bus coherency across pins
   always_ff @(posedge clk_apb or negedge rst_apb_n) begin
      if (rst_apb_n == 1'b0) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= pad_in;
         sync_q <= meta_q;
      end
   end

   // Previous sample register
   // A pad held high through reset gives one rise afterwards
   always_ff @(posedge clk_apb or negedge rst_apb_n) begin
      if (rst_apb_n == 1'b0) begin
         prev_q <= '0;
      end else begin
         prev_q <= sync_q;
      end
   end

   // Edge compare between two flop outputs
   // High for one cycle right after sync_in changed
   // Both sides come from flops so the pulse is glitch free
   always_comb begin
      // Low to high on the synchronized input
      rise_evt = sync_q & ~prev_q;
      // High to low
      fall_evt = ~sync_q & prev_q;
   end

   // Synchronized level for DATA_IN reads
   assign sync_in = sync_q;

endmodule

// ==== gpio_irq_ctrl.sv ====
`timescale 1ns/1ps

module gpio_irq_ctrl import gpio_pkg::*; (
   input  logic              clk_apb,
   input  logic              rst_apb_n,
   // Edge pulses from the capture stage
   input  logic [gpio_n-1:0] rise_evt,
   input  logic [gpio_n-1:0] fall_evt,
   // Per-pin enables from the register block
   input  logic [gpio_n-1:0] rise_en,
   input  logic [gpio_n-1:0] fall_en,
   // Write-one-to-clear pulse vector
   input  logic [gpio_n-1:0] status_clr,
   // Sticky status back to the register block
   output logic [gpio_n-1:0] status,
   // Level interrupt to the outside
   output logic              irq
);

   logic [gpio_n-1:0] status_q;
   logic [gpio_n-1:0] status_nxt;
   logic [gpio_n-1:0] evt_hit;
   logic              irq_q;

   // Enabled events this cycle
   // Rise and fall share one status bit per pin
   assign evt_hit = (rise_evt & rise_en) | (fall_evt & fall_en);

   // Next status
   // Clear first, then set, so a new event beats the clear
   assign status_nxt = (status_q & ~status_clr) | evt_hit;

   // Status flops and interrupt line
   // irq comes from the next value so it moves with status
   always_ff @(posedge clk_apb or negedge rst_apb_n) begin
      if (rst_apb_n == 1'b0) begin
         status_q <= '0;
         irq_q    <= 1'b0;
      end else begin
         status_q <= status_nxt;
         // Any pending bit keeps the line up
         irq_q    <= |status_nxt;
      end
   end

   // Outputs straight from flops
   assign status = status_q;
   assign irq    = irq_q;

endmodule

// ==== gpio_pkg.sv ====
package gpio_pkg;

   // Pin count of the block
   localparam int gpio_n = 32;

   // Width of the register word index
   // Covers address bits 4 to 2
   localparam int reg_idx_w = 3;

   // Register word indices
   // DATA_OUT is read and write
   localparam logic [reg_idx_w-1:0] reg_data_out   = 3'd0;
   // DATA_IN holds the synchronized pads and is read only
   localparam logic [reg_idx_w-1:0] reg_data_in    = 3'd1;
   // Rising edge interrupt enables
   localparam logic [reg_idx_w-1:0] reg_rise_en    = 3'd2;
   // Falling edge interrupt enables
   localparam logic [reg_idx_w-1:0] reg_fall_en    = 3'd3;
   // Sticky edge status with write one to clear
   localparam logic [reg_idx_w-1:0] reg_irq_status = 3'd4;
   // Indices 5 to 7 are holes that read zero and drop writes

   // Reset values
   // All pads driven low out of reset
   localparam logic [gpio_n-1:0] data_out_rst = '0;
   // No edge enabled out of reset
   localparam logic [gpio_n-1:0] rise_en_rst  = '0;
   localparam logic [gpio_n-1:0] fall_en_rst  = '0;

endpackage

// ==== gpio_top.sv ====
`timescale 1ns/1ps

module gpio_top import apb_pkg::*, gpio_pkg::*; (
   input  logic                  clk_apb,
   input  logic                  rst_apb_n,
   // APB slave port
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [apb_addr_w-1:0] paddr,
   input  logic [apb_data_w-1:0] pwdata,
   output logic [apb_data_w-1:0] prdata,
   output logic                  pready,
   output logic                  pslverr,
   // Pads
   input  logic [gpio_n-1:0]     pad_in,
   output logic [gpio_n-1:0]     pad_out,
   // Level interrupt
   output logic                  irq
);

   // Capture stage to register block and irq stage
   logic [gpio_n-1:0] sync_in;
   logic [gpio_n-1:0] rise_evt;
   logic [gpio_n-1:0] fall_evt;
   // Register block to irq stage
   logic [gpio_n-1:0] rise_en;
   logic [gpio_n-1:0] fall_en;
   logic [gpio_n-1:0] status_clr;
   // irq stage back to the register block
   logic [gpio_n-1:0] status;

   // Register block
   gpio_apb_regs u_regs (
      .clk_apb    (clk_apb),
      .rst_apb_n  (rst_apb_n),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .sync_in    (sync_in),
      .status     (status),
      .pad_out    (pad_out),
      .rise_en    (rise_en),
      .fall_en    (fall_en),
      .status_clr (status_clr)
   );

   // Pad stage 1 with sync and edge detect
   gpio_in_capture u_capture (
      .clk_apb   (clk_apb),
      .rst_apb_n (rst_apb_n),
      .pad_in    (pad_in),
      .sync_in   (sync_in),
      .rise_evt  (rise_evt),
      .fall_evt  (fall_evt)
   );

   // Pad stage 2 with status and interrupt
   gpio_irq_ctrl u_irq (
      .clk_apb    (clk_apb),
      .rst_apb_n  (rst_apb_n),
      .rise_evt   (rise_evt),
      .fall_evt   (fall_evt),
      .rise_en    (rise_en),
      .fall_en    (fall_en),
      .status_clr (status_clr),
      .status     (status),
      .irq        (irq)
   );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the GPIO testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file="sim.log"
sim_bin="tb_gpio_sim"

# Assertions on, timing for the testbench delays
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_gpio -f vlog.f -o "$sim_bin"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

# Run and keep the output in the log
./obj_dir/"$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

# Verdict from the log
if grep -q "TESTBENCH FAILED" "$log_file"; then
   exit 1
fi
exit 0

// ==== tb_gpio.sv ====
`timescale 1ns/1ps

module tb_gpio import apb_pkg::*, gpio_pkg::*; ();

   // Loop lengths per test section
   localparam int n_cfg = 24;
   localparam int n_din = 16;
   localparam int n_irq = 40;
   localparam int n_clr = 24;
   localparam int n_ro  = 6;
   // APB transfers over the whole run
   localparam int n_xfer = 8 + 2 * n_cfg + n_din + 2 + n_irq + 2 * n_clr + 4 + 6 * n_ro;
   // 200 cycles of 100 ns per transfer
   localparam longint watchdog_ns = longint'(n_xfer) * 200 * 100;

   logic                  clk_apb;
   logic                  rst_apb_n;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [apb_addr_w-1:0] paddr;
   logic [apb_data_w-1:0] pwdata;
   logic [apb_data_w-1:0] prdata;
   logic                  pready;
   logic                  pslverr;
   logic [gpio_n-1:0]     pad_in;
   logic [gpio_n-1:0]     pad_out;
   logic                  irq;

   // Reference model state
   // Three-deep pad history mirrors the sync chain and previous sample
   logic [gpio_n-1:0] m_meta     = '0;
   logic [gpio_n-1:0] m_sync     = '0;
   logic [gpio_n-1:0] m_prev     = '0;
   logic [gpio_n-1:0] m_data_out = '0;
   logic [gpio_n-1:0] m_rise_en  = '0;
   logic [gpio_n-1:0] m_fall_en  = '0;
   logic [gpio_n-1:0] m_status   = '0;
   logic [gpio_n-1:0] m_evt;
   logic [gpio_n-1:0] m_clr;

   int          err_cnt;
   int          chk_cnt;
   int unsigned seed_ret;

   gpio_top DUT (
      .clk_apb   (clk_apb),
      .rst_apb_n (rst_apb_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .pslverr   (pslverr),
      .pad_in    (pad_in),
      .pad_out   (pad_out),
      .irq       (irq)
   );

   // 100 ns clock
   always #50 clk_apb = ~clk_apb;

   // Model update at each rising edge
   // Edge rule uses the old history and old enables
   // Set beats clear
   always @(posedge clk_apb) begin
      if (rst_apb_n == 1'b0) begin
         m_meta     = '0;
         m_sync     = '0;
         m_prev     = '0;
         m_data_out = '0;
         m_rise_en  = '0;
         m_fall_en  = '0;
         m_status   = '0;
      end else begin
         m_evt = (m_sync & ~m_prev & m_rise_en) | (~m_sync & m_prev & m_fall_en);
         m_clr = '0;
         // Setup phase write
         if (psel && !penable && pwrite) begin
            case (paddr[apb_word_lsb +: reg_idx_w])
               reg_data_out:   m_data_out = pwdata;
               reg_rise_en:    m_rise_en  = pwdata;
               reg_fall_en:    m_fall_en  = pwdata;
               reg_irq_status: m_clr      = pwdata;
               default: ;
            endcase
         end
         m_status = (m_status & ~m_clr) | m_evt;
         m_prev   = m_sync;
         m_sync   = m_meta;
         m_meta   = pad_in;
      end
   end

   // Expected read word
   function automatic logic [31:0] model_word(input logic [reg_idx_w-1:0] idx);
      case (idx)
         reg_data_out:   return m_data_out;
         reg_data_in:    return m_sync;
         reg_rise_en:    return m_rise_en;
         reg_fall_en:    return m_fall_en;
         reg_irq_status: return m_status;
         default:        return 32'h0;
      endcase
   endfunction

   task automatic check_val(input string name, input logic [31:0] act,
                            input logic [31:0] exp);
      chk_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("ERR %s: got %08h, expected %08h at %0t", name, act, exp, $time);
      end
   endtask

   // Two-cycle write with setup then access
   task automatic apb_write(input logic [reg_idx_w-1:0] idx, input logic [31:0] data);
      @(posedge clk_apb);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = apb_addr_w'(idx) << apb_word_lsb;
      pwdata  = data;
      @(posedge clk_apb);
      #1;
      penable = 1'b1;
      @(posedge clk_apb);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   // Two-cycle read
   // Setup phase data and model go back to the caller
   // Access phase data is checked here against the model
   task automatic apb_read(input logic [reg_idx_w-1:0] idx, output logic [31:0] act,
                           output logic [31:0] exp);
      @(posedge clk_apb);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = apb_addr_w'(idx) << apb_word_lsb;
      @(negedge clk_apb);
      act = prdata;
      exp = model_word(idx);
      @(posedge clk_apb);
      #1;
      penable = 1'b1;
      @(negedge clk_apb);
      check_val($sformatf("prdata access word %0d", idx), prdata, model_word(idx));
      @(posedge clk_apb);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic read_check(input logic [reg_idx_w-1:0] idx);
      logic [31:0] act;
      logic [31:0] exp;
      apb_read(idx, act, exp);
      check_val($sformatf("prdata word %0d", idx), act, exp);
   endtask

   // Sparse random toggle of a few pins
   task automatic toggle_pads();
      @(posedge clk_apb);
      #1;
      pad_in = pad_in ^ ($urandom & $urandom);
   endtask

   // Level outputs checked every cycle
   always @(negedge clk_apb) begin
      if (rst_apb_n == 1'b1) begin
         check_val("irq", 32'(irq), 32'(|m_status));
         check_val("pad_out", pad_out, m_data_out);
      end
   end

   initial begin
      #(watchdog_ns);
      $display("Watchdog expired after %0d ns, the test did not finish", watchdog_ns);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin : main_flow
      logic [31:0]          act;
      logic [31:0]          exp;
      logic [reg_idx_w-1:0] idx;
      int                   pick;
      clk_apb   = 1'b0;
      rst_apb_n = 1'b0;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      pad_in    = '0;
      err_cnt   = 0;
      chk_cnt   = 0;
      seed_ret  = $urandom(32'h7c41_10e5);
      repeat (2) @(posedge clk_apb);
      #1 rst_apb_n = 1'b1;

      // Reset values including the holes
      for (int w = 0; w < 8; w++) begin
         apb_read(reg_idx_w'(w), act, exp);
         check_val($sformatf("reset word %0d", w), act, 32'h0);
      end

      // Config write and read back
      for (int i = 0; i < n_cfg; i++) begin
         pick = $urandom_range(0, 2);
         idx  = (pick == 0) ? reg_data_out : ((pick == 1) ? reg_rise_en : reg_fall_en);
         apb_write(idx, $urandom);
         read_check(idx);
      end

      // DATA_IN with pads held still
      for (int i = 0; i < n_din; i++) begin
         @(posedge clk_apb);
         #1 pad_in = $urandom;
         repeat (3) @(posedge clk_apb);
         read_check(reg_data_in);
      end

      // Edge status under random enables and pad activity
      apb_write(reg_rise_en, $urandom);
      apb_write(reg_fall_en, $urandom);
      for (int i = 0; i < n_irq; i++) begin
         toggle_pads();
         repeat ($urandom_range(1, 4)) @(posedge clk_apb);
         read_check(reg_irq_status);
      end

      // Write-one-to-clear with random masks
      for (int i = 0; i < n_clr; i++) begin
         toggle_pads();
         // Random gap lets a clear meet a new edge in the same cycle
         repeat ($urandom_range(0, 2)) @(posedge clk_apb);
         apb_write(reg_irq_status, $urandom & $urandom);
         read_check(reg_irq_status);
      end
      // Quiet the inputs, then clear everything
      apb_write(reg_rise_en, 32'h0);
      apb_write(reg_fall_en, 32'h0);
      repeat (4) @(posedge clk_apb);
      apb_write(reg_irq_status, 32'hffff_ffff);
      read_check(reg_irq_status);
      @(negedge clk_apb);
      check_val("irq after clear", 32'(irq), 32'h0);

      // Read-only and unmapped words drop writes
      for (int i = 0; i < n_ro; i++) begin
         pick = $urandom_range(0, 3);
         idx  = (pick == 0) ? reg_data_in : reg_idx_w'(pick + 4);
         apb_write(idx, $urandom);
         for (int w = 0; w < 5; w++) begin
            read_check(reg_idx_w'(w));
         end
      end

      repeat (2) @(posedge clk_apb);
      $display("Run done: %0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
apb_pkg.sv
gpio_pkg.sv
gpio_in_capture.sv
gpio_irq_ctrl.sv
gpio_apb_regs.sv
gpio_top.sv
gpio_chk.sv
tb_gpio.sv
